/* verilog/cpu16_pkg.sv */
package cpu16_pkg;

	localparam int WORD_BITS     = 16;
	localparam int REG_ADDR_BITS = 4;	// sixteen registers
	localparam int IMM_HI_BITS   = 12;
	localparam int NUM_REGS      = 2 ** REG_ADDR_BITS;

	// instruction field positions, msb of each field
	localparam int OP_MSB     = 15;	// major opcode nibble
	localparam int SUB_MSB    = 11;	// alu op, or nop / inc / dec select
	localparam int COND_MSB   = 10;	// branch condition, 3 bits
	localparam int DST_MSB    = 7;
	localparam int SRC_MSB    = 3;
	localparam int BR_IND_BIT = 11;	// must be zero on a branch
	localparam int STORE_BIT  = 8;	// 0 load, 1 store

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [REG_ADDR_BITS-1:0] reg_idx_t;

	localparam word_t NOP_WORD  = '0;
	localparam word_t DONE_ADDR = 16'h00FF;	// a store here ends a test program

	typedef enum logic [3:0] {
		NOP_GRP = 4'h0,
		IMM     = 4'h1,
		ALU_RR  = 4'h2,
		ALU_RI  = 4'h3,
		BRANCH  = 4'h4,
		LDST    = 4'h6
	} major_op_e;

	// second nibble inside NOP_GRP
	typedef enum logic [3:0] {
		SUB_NOP = 4'h0,
		SUB_INC = 4'h2,
		SUB_DEC = 4'h3
	} nop_sub_e;

	typedef enum logic [3:0] {
		MOV = 4'h0,
		ADD = 4'h1,
		SUB = 4'h2,
		AND = 4'h3,
		OR  = 4'h4,
		XOR = 4'h5,
		SHL = 4'h6,
		SHR = 4'h7
	} alu_op_e;	// 8..15 give zero and clear flags

	typedef enum logic [2:0] {
		BZ     = 3'd0,
		BNZ    = 3'd1,
		BS     = 3'd2,
		BNS    = 3'd3,
		BC     = 3'd4,
		BNC    = 3'd5,
		BA     = 3'd6,
		BNEVER = 3'd7
	} branch_cond_e;

	typedef struct packed {
		logic c;
		logic z;
		logic s;
	} flags_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  rd;
		logic  wr;
	} mem_req_t;

	typedef struct packed {
		word_t ins;
		word_t imm;	// prefix and low nibble already joined
	} exec_ctrl_t;

	typedef struct packed {
		logic     we;
		reg_idx_t addr;
		word_t    data;
	} wb_t;

endpackage

/* verilog/alu16.sv */
module alu16 (
	input  cpu16_pkg::alu_op_e op,
	input  cpu16_pkg::word_t   a,
	input  cpu16_pkg::word_t   b,
	output cpu16_pkg::word_t   y,
	output cpu16_pkg::flags_t  f
);

	logic [cpu16_pkg::WORD_BITS:0] ext;	// one extra bit for carry or shifted-out bit
	logic [3:0]                    sh;
	cpu16_pkg::word_t              res;
	logic                          c;

	assign sh = b[3:0];

	always_comb begin
		ext = '0;
		res = '0;
		c   = 1'b0;
		case (op)
			cpu16_pkg::MOV: res = b;
			cpu16_pkg::ADD: begin
				ext      = {1'b0, a} + {1'b0, b};
				{c, res} = ext;
			end
			cpu16_pkg::SUB: begin
				ext      = {1'b0, a} - {1'b0, b};
				{c, res} = ext;	// borrow
			end
			cpu16_pkg::AND: res = a & b;
			cpu16_pkg::OR:  res = a | b;
			cpu16_pkg::XOR: res = a ^ b;
			cpu16_pkg::SHL: begin
				ext      = {1'b0, a} << sh;
				{c, res} = ext;
			end
			cpu16_pkg::SHR: begin
				ext      = {a, 1'b0} >> sh;
				{res, c} = ext;	// last bit out lands below the result
			end
			default: ;
		endcase
	end

	assign y = res;

	always_comb begin
		f = '0;
		if (!op[3]) begin	// undefined codes leave all flags clear
			f.c = c;
			f.z = (res == '0);
			f.s = res[cpu16_pkg::WORD_BITS-1];
		end
	end

endmodule

/* verilog/register_file.sv */
module register_file (
	input  logic                CLK,
	input  logic                RSTb,
	input  cpu16_pkg::reg_idx_t rd_a_addr,
	input  cpu16_pkg::reg_idx_t rd_b_addr,
	output cpu16_pkg::word_t    rd_a,
	output cpu16_pkg::word_t    rd_b,
	input  cpu16_pkg::wb_t      wb
);

	cpu16_pkg::word_t regs [cpu16_pkg::NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < cpu16_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// no write-through, decode holds readers until the write lands
	assign rd_a = regs[rd_a_addr];
	assign rd_b = regs[rd_b_addr];

endmodule

/* verilog/fetch_mem_port.sv */
module fetch_mem_port (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic                stall,
	input  logic                redirect,
	input  cpu16_pkg::word_t    redirect_pc,
	input  cpu16_pkg::mem_req_t data_req,
	output cpu16_pkg::mem_req_t mem
);

	cpu16_pkg::word_t pc;		// next sequential fetch address
	cpu16_pkg::word_t pc_prev;	// fetch whose word is now on mem_rdata
	cpu16_pkg::word_t want_pc;	// next word decode still needs
	logic             data_last;	// last cycle was a data access
	logic             data_act;

	assign data_act = data_req.rd | data_req.wr;

	always_comb begin
		if (redirect) begin
			want_pc = redirect_pc;
		end else if (stall && !data_last) begin
			want_pc = pc_prev;	// word on rdata is dropped, fetch it again
		end else begin
			want_pc = pc;
		end
	end

	// data access in stage 3 takes the port over the fetch
	always_comb begin
		mem.wdata = data_req.wdata;
		if (data_act) begin
			mem.addr = data_req.addr;
			mem.rd   = data_req.rd;
			mem.wr   = data_req.wr;
		end else begin
			mem.addr = want_pc;
			mem.rd   = 1'b1;
			mem.wr   = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc        <= '0;
			pc_prev   <= '0;
			data_last <= 1'b0;
		end else begin
			data_last <= data_act;
			if (data_act) begin
				pc <= want_pc;	// hold, or rewind / redirect without a fetch
			end else begin
				pc      <= want_pc + 16'd1;
				pc_prev <= want_pc;
			end
		end
	end

endmodule

/* verilog/decode_stage.sv */
module decode_stage (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  cpu16_pkg::word_t      mem_rdata,
	input  logic                  load_wb,
	input  cpu16_pkg::flags_t     flags,
	input  cpu16_pkg::reg_idx_t   pend_dst2,
	input  cpu16_pkg::reg_idx_t   pend_dst3,
	input  cpu16_pkg::reg_idx_t   pend_dst4,
	input  logic [2:0]            pend_vld,
	input  logic                  alu_busy,
	output cpu16_pkg::exec_ctrl_t exec_ctrl,
	output logic                  stall,
	output logic                  redirect,
	output cpu16_pkg::word_t      redirect_pc
);

	cpu16_pkg::word_t                 ins;
	logic                             ins_vld;	// low for bubbles put in by the pipeline
	logic                             rdata_vld;	// rdata holds nothing in the first cycle
	logic [cpu16_pkg::IMM_HI_BITS-1:0] imm_hi;
	cpu16_pkg::major_op_e             major;
	cpu16_pkg::nop_sub_e              sub;
	cpu16_pkg::word_t                 imm;
	cpu16_pkg::reg_idx_t              dst;
	cpu16_pkg::reg_idx_t              src;
	logic                             use_dst;
	logic                             use_src;
	logic                             is_branch;
	logic                             cond;

	assign major = cpu16_pkg::major_op_e'(ins[cpu16_pkg::OP_MSB -: 4]);
	assign sub   = cpu16_pkg::nop_sub_e'(ins[cpu16_pkg::SUB_MSB -: 4]);
	assign dst   = ins[cpu16_pkg::DST_MSB -: cpu16_pkg::REG_ADDR_BITS];
	assign src   = ins[cpu16_pkg::SRC_MSB -: cpu16_pkg::REG_ADDR_BITS];
	assign imm   = {imm_hi, ins[cpu16_pkg::SRC_MSB:0]};

	// true when r is written by an instruction in stages 2..4
	function automatic logic pending(input cpu16_pkg::reg_idx_t r);
		return (pend_vld[0] && pend_dst2 == r) ||
			(pend_vld[1] && pend_dst3 == r) ||
			(pend_vld[2] && pend_dst4 == r);
	endfunction

	// registers read or written by the instruction in decode
	always_comb begin
		use_dst = 1'b0;
		use_src = 1'b0;
		case (major)
			cpu16_pkg::NOP_GRP: use_src = sub inside {cpu16_pkg::SUB_INC, cpu16_pkg::SUB_DEC};
			cpu16_pkg::ALU_RR: begin
				use_dst = 1'b1;
				use_src = 1'b1;
			end
			cpu16_pkg::ALU_RI, cpu16_pkg::LDST: use_dst = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (cpu16_pkg::branch_cond_e'(ins[cpu16_pkg::COND_MSB -: 3]))
			cpu16_pkg::BZ:  cond = flags.z;
			cpu16_pkg::BNZ: cond = ~flags.z;
			cpu16_pkg::BS:  cond = flags.s;
			cpu16_pkg::BNS: cond = ~flags.s;
			cpu16_pkg::BC:  cond = flags.c;
			cpu16_pkg::BNC: cond = ~flags.c;
			cpu16_pkg::BA:  cond = 1'b1;
			default:        cond = 1'b0;	// BNEVER
		endcase
	end

	assign is_branch = (major == cpu16_pkg::BRANCH);

	// flags are only trusted once no alu op is left in stage 2 or 3
	assign stall = (use_dst && pending(dst)) || (use_src && pending(src)) ||
		(is_branch && alu_busy);

	assign redirect    = is_branch && !stall && cond && !ins[cpu16_pkg::BR_IND_BIT];
	assign redirect_pc = imm;

	always_comb begin
		if (stall) begin
			exec_ctrl.ins = cpu16_pkg::NOP_WORD;	// bubble into execute
			exec_ctrl.imm = '0;
		end else begin
			exec_ctrl.ins = ins;
			exec_ctrl.imm = imm;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ins       <= cpu16_pkg::NOP_WORD;
			ins_vld   <= 1'b0;
			rdata_vld <= 1'b0;
			imm_hi    <= '0;
		end else begin
			rdata_vld <= 1'b1;
			if (!stall) begin
				// prefix lives for exactly one real instruction
				if (ins_vld)
					imm_hi <= (major == cpu16_pkg::IMM) ? ins[cpu16_pkg::SUB_MSB:0] : '0;
				if (redirect || load_wb || !rdata_vld) begin
					ins     <= cpu16_pkg::NOP_WORD;	// squashed slot
					ins_vld <= 1'b0;
				end else begin
					ins     <= mem_rdata;
					ins_vld <= 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/execute_stage.sv */
module execute_stage (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  cpu16_pkg::exec_ctrl_t exec_ctrl,
	input  cpu16_pkg::word_t      rd_a,
	input  cpu16_pkg::word_t      rd_b,
	output cpu16_pkg::reg_idx_t   rd_a_addr,
	output cpu16_pkg::reg_idx_t   rd_b_addr,
	input  cpu16_pkg::word_t      mem_rdata,
	output cpu16_pkg::mem_req_t   data_req,
	output logic                  load_wb,
	output cpu16_pkg::flags_t     flags,
	output cpu16_pkg::reg_idx_t   pend_dst2,
	output cpu16_pkg::reg_idx_t   pend_dst3,
	output cpu16_pkg::reg_idx_t   pend_dst4,
	output logic [2:0]            pend_vld,
	output logic                  alu_busy,
	output cpu16_pkg::wb_t        wb
);

	cpu16_pkg::exec_ctrl_t ex2;
	cpu16_pkg::word_t      ins3;
	cpu16_pkg::word_t      res3;	// result, or store data
	cpu16_pkg::word_t      addr3;
	cpu16_pkg::word_t      ins4;
	cpu16_pkg::word_t      res4;
	cpu16_pkg::major_op_e  op2;
	cpu16_pkg::major_op_e  op3;
	cpu16_pkg::major_op_e  op4;
	cpu16_pkg::alu_op_e    alu_op;
	cpu16_pkg::word_t      alu_b;
	cpu16_pkg::word_t      alu_y;
	cpu16_pkg::flags_t     alu_f;
	cpu16_pkg::word_t      res2;
	logic                  alu2;

	function automatic cpu16_pkg::major_op_e major_of(input cpu16_pkg::word_t ins);
		return cpu16_pkg::major_op_e'(ins[cpu16_pkg::OP_MSB -: 4]);
	endfunction

	function automatic cpu16_pkg::nop_sub_e sub_of(input cpu16_pkg::word_t ins);
		return cpu16_pkg::nop_sub_e'(ins[cpu16_pkg::SUB_MSB -: 4]);
	endfunction

	// inc / dec name their register in the low nibble, everything else in bits 7:4
	function automatic cpu16_pkg::reg_idx_t dst_of(input cpu16_pkg::word_t ins);
		if (major_of(ins) == cpu16_pkg::NOP_GRP)
			return ins[cpu16_pkg::SRC_MSB -: cpu16_pkg::REG_ADDR_BITS];
		return ins[cpu16_pkg::DST_MSB -: cpu16_pkg::REG_ADDR_BITS];
	endfunction

	function automatic logic writes_reg(input cpu16_pkg::word_t ins);
		case (major_of(ins))
			cpu16_pkg::NOP_GRP: return sub_of(ins) inside {cpu16_pkg::SUB_INC, cpu16_pkg::SUB_DEC};
			cpu16_pkg::ALU_RR, cpu16_pkg::ALU_RI: return 1'b1;
			cpu16_pkg::LDST: return !ins[cpu16_pkg::STORE_BIT];
			default: return 1'b0;
		endcase
	endfunction

	// stage 2: operands and result
	assign op2       = major_of(ex2.ins);
	assign rd_a_addr = dst_of(ex2.ins);
	assign rd_b_addr = ex2.ins[cpu16_pkg::SRC_MSB -: cpu16_pkg::REG_ADDR_BITS];
	assign alu_op    = cpu16_pkg::alu_op_e'(ex2.ins[cpu16_pkg::SUB_MSB -: 4]);
	assign alu_b     = (op2 == cpu16_pkg::ALU_RI) ? ex2.imm : rd_b;
	assign alu2      = op2 inside {cpu16_pkg::ALU_RR, cpu16_pkg::ALU_RI};

	alu16 u_alu (.op(alu_op), .a(rd_a), .b(alu_b), .y(alu_y), .f(alu_f));

	always_comb begin
		case (op2)
			cpu16_pkg::NOP_GRP: begin
				case (sub_of(ex2.ins))
					cpu16_pkg::SUB_INC: res2 = rd_a + 16'd1;
					cpu16_pkg::SUB_DEC: res2 = rd_a - 16'd1;
					default:            res2 = '0;
				endcase
			end
			cpu16_pkg::ALU_RR, cpu16_pkg::ALU_RI: res2 = alu_y;
			cpu16_pkg::LDST: res2 = rd_a;	// store data rides along
			default: res2 = '0;
		endcase
	end

	// stage 3: memory port request
	assign op3 = major_of(ins3);
	always_comb begin
		data_req.addr  = addr3;
		data_req.wdata = res3;
		data_req.rd    = (op3 == cpu16_pkg::LDST) && !ins3[cpu16_pkg::STORE_BIT];
		data_req.wr    = (op3 == cpu16_pkg::LDST) && ins3[cpu16_pkg::STORE_BIT];
	end

	// stage 4: writeback, rdata holds load data and not an instruction
	assign op4     = major_of(ins4);
	assign load_wb = (op4 == cpu16_pkg::LDST);
	always_comb begin
		wb.we   = writes_reg(ins4);
		wb.addr = dst_of(ins4);
		wb.data = (op4 == cpu16_pkg::LDST) ? mem_rdata : res4;
	end

	assign pend_dst2 = dst_of(ex2.ins);
	assign pend_dst3 = dst_of(ins3);
	assign pend_dst4 = dst_of(ins4);
	assign pend_vld  = {writes_reg(ins4), writes_reg(ins3), writes_reg(ex2.ins)};
	assign alu_busy  = alu2 || (op3 inside {cpu16_pkg::ALU_RR, cpu16_pkg::ALU_RI});

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ex2   <= '{ins: cpu16_pkg::NOP_WORD, imm: '0};
			ins3  <= cpu16_pkg::NOP_WORD;
			ins4  <= cpu16_pkg::NOP_WORD;
			flags <= '0;
		end else begin
			ex2  <= exec_ctrl;
			ins3 <= ex2.ins;
			ins4 <= ins3;
			if (alu2)
				flags <= alu_f;	// inc / dec keep the flags
		end
	end

	always_ff @(posedge CLK) begin
		res3  <= res2;
		addr3 <= ex2.imm;
		res4  <= res3;
	end

endmodule

/* verilog/cpu16_top.sv */
module cpu16_top (
	input  logic                CLK,
	input  logic                RSTb,
	output cpu16_pkg::mem_req_t mem,
	input  cpu16_pkg::word_t    mem_rdata
);

	logic                  stall;
	logic                  redirect;
	cpu16_pkg::word_t      redirect_pc;
	cpu16_pkg::mem_req_t   data_req;
	cpu16_pkg::exec_ctrl_t exec_ctrl;
	logic                  load_wb;
	cpu16_pkg::flags_t     flags;
	cpu16_pkg::reg_idx_t   pend_dst2;
	cpu16_pkg::reg_idx_t   pend_dst3;
	cpu16_pkg::reg_idx_t   pend_dst4;
	logic [2:0]            pend_vld;
	logic                  alu_busy;
	cpu16_pkg::reg_idx_t   rd_a_addr;
	cpu16_pkg::reg_idx_t   rd_b_addr;
	cpu16_pkg::word_t      rd_a;
	cpu16_pkg::word_t      rd_b;
	cpu16_pkg::wb_t        wb;

	fetch_mem_port u_fetch (
		.CLK(CLK), .RSTb(RSTb),
		.stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.data_req(data_req), .mem(mem)
	);

	decode_stage u_decode (
		.CLK(CLK), .RSTb(RSTb),
		.mem_rdata(mem_rdata), .load_wb(load_wb), .flags(flags),
		.pend_dst2(pend_dst2), .pend_dst3(pend_dst3), .pend_dst4(pend_dst4),
		.pend_vld(pend_vld), .alu_busy(alu_busy),
		.exec_ctrl(exec_ctrl), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	execute_stage u_execute (
		.CLK(CLK), .RSTb(RSTb),
		.exec_ctrl(exec_ctrl), .rd_a(rd_a), .rd_b(rd_b),
		.rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr),
		.mem_rdata(mem_rdata), .data_req(data_req), .load_wb(load_wb), .flags(flags),
		.pend_dst2(pend_dst2), .pend_dst3(pend_dst3), .pend_dst4(pend_dst4),
		.pend_vld(pend_vld), .alu_busy(alu_busy), .wb(wb)
	);

	register_file u_regs (
		.CLK(CLK), .RSTb(RSTb),
		.rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr),
		.rd_a(rd_a), .rd_b(rd_b), .wb(wb)
	);

endmodule

/* test/tb_checker.sv */
module tb_checker (
	input  logic                CLK,
	input  logic                RSTb,
	input  cpu16_pkg::mem_req_t mem,
	input  int                  test_idx,
	input  int                  exp_cnt,
	input  cpu16_pkg::word_t    exp_addr [4],
	input  cpu16_pkg::word_t    exp_data [4],
	input  int                  cycle_limit,
	output logic                done,
	output logic                timed_out,
	output int                  pass_tests,
	output int                  fail_tests
);

	timeunit 1ns;
	timeprecision 100ps;

	int cycles;	// whole run including reset
	int n_st;	// stores seen in this test
	int errs;

	initial begin
		done       <= 1'b0;
		timed_out  <= 1'b0;
		pass_tests <= 0;
		fail_tests <= 0;
		cycles     = 0;
		n_st       = 0;
		errs       = 0;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit && !timed_out) begin
			$display("timeout: test %0d never reached its done store in %0d cycles",
				test_idx, cycles);
			timed_out <= 1'b1;
		end
		if (!RSTb) begin
			n_st = 0;
			errs = 0;
			done <= 1'b0;
		end else if (!done) begin
			// every cycle but a store is a fetch or a data read
			if (mem.rd != !mem.wr) begin
				$display("mismatch mem.rd test %0d: expected %h, got %h",
					test_idx, !mem.wr, mem.rd);
				errs = errs + 1;
			end
			if (mem.wr) begin
				if (mem.addr == cpu16_pkg::DONE_ADDR) begin
					if (n_st != exp_cnt) begin
						$display("test %0d: %0d stores came before the done store, %0d expected",
							test_idx, n_st, exp_cnt);
						errs = errs + 1;
					end
					if (errs == 0) begin
						$display("test %0d passed, %0d stores", test_idx, n_st);
						pass_tests <= pass_tests + 1;
					end else begin
						$display("test %0d failed, %0d errors", test_idx, errs);
						fail_tests <= fail_tests + 1;
					end
					done <= 1'b1;
				end else if (n_st >= exp_cnt) begin
					$display("test %0d: extra store to address %h", test_idx, mem.addr);
					errs = errs + 1;
					n_st = n_st + 1;
				end else begin
					if (mem.addr != exp_addr[n_st]) begin
						$display("mismatch mem.addr test %0d store %0d: expected %h, got %h",
							test_idx, n_st, exp_addr[n_st], mem.addr);
						errs = errs + 1;
					end
					if (mem.wdata != exp_data[n_st]) begin
						$display("mismatch mem.wdata test %0d store %0d: expected %h, got %h",
							test_idx, n_st, exp_data[n_st], mem.wdata);
						errs = errs + 1;
					end
					n_st = n_st + 1;
				end
			end
		end
	end

endmodule

/* test/tb_top.sv */
module tb_top;

	timeunit 1ns;
	timeprecision 100ps;

	logic                CLK;
	logic                RSTb;
	cpu16_pkg::mem_req_t mem;
	cpu16_pkg::word_t    mem_rdata;

	cpu16_pkg::word_t ram [256];

	// test table of program words and the expected stores in order
	cpu16_pkg::word_t prog [16][16];
	int               plen [16];
	int               ecnt [16];
	cpu16_pkg::word_t eaddr [16][4];
	cpu16_pkg::word_t edata [16][4];
	int               nt;	// tests built so far
	int               np;	// words in the program being built
	int               seed;

	int               test_idx;
	int               cur_cnt;
	cpu16_pkg::word_t cur_addr [4];
	cpu16_pkg::word_t cur_data [4];
	int               cycle_limit;
	logic             done;
	logic             timed_out;
	int               pass_tests;
	int               fail_tests;

	cpu16_top dut_i (.CLK(CLK), .RSTb(RSTb), .mem(mem), .mem_rdata(mem_rdata));

	tb_checker check_i (
		.CLK(CLK), .RSTb(RSTb), .mem(mem), .test_idx(test_idx),
		.exp_cnt(cur_cnt), .exp_addr(cur_addr), .exp_data(cur_data),
		.cycle_limit(cycle_limit), .done(done), .timed_out(timed_out),
		.pass_tests(pass_tests), .fail_tests(fail_tests)
	);

	always #10 CLK = ~CLK;

	// one cycle read latency, write on the strobe
	always @(posedge CLK) begin
		if (mem.wr)
			ram[mem.addr[7:0]] <= mem.wdata;
		mem_rdata <= #1 ram[mem.addr[7:0]];
	end

	// reference results with the carry or borrow in bit 16
	function automatic logic [16:0] alu_expect(input cpu16_pkg::alu_op_e op,
		input cpu16_pkg::word_t a, input cpu16_pkg::word_t b);
		logic [3:0] sh;
		sh = b[3:0];
		case (op)
			cpu16_pkg::MOV: return {1'b0, b};
			cpu16_pkg::ADD: return {1'b0, a} + {1'b0, b};
			cpu16_pkg::SUB: return {1'b0, a} - {1'b0, b};
			cpu16_pkg::AND: return {1'b0, a & b};
			cpu16_pkg::OR:  return {1'b0, a | b};
			cpu16_pkg::XOR: return {1'b0, a ^ b};
			cpu16_pkg::SHL: return (sh == 0) ? {1'b0, a} : {a[16 - sh], a << sh};
			cpu16_pkg::SHR: return (sh == 0) ? {1'b0, a} : {a[sh - 1], a >> sh};
			default: return '0;
		endcase
	endfunction

	function automatic logic branch_taken(input cpu16_pkg::branch_cond_e cond,
		input logic [16:0] r);
		logic z;
		z = (r[15:0] == 16'h0);
		case (cond)
			cpu16_pkg::BZ:  return z;
			cpu16_pkg::BNZ: return !z;
			cpu16_pkg::BS:  return r[15];
			cpu16_pkg::BNS: return !r[15];
			cpu16_pkg::BC:  return r[16];
			cpu16_pkg::BNC: return !r[16];
			cpu16_pkg::BA:  return 1'b1;
			default:        return 1'b0;
		endcase
	endfunction

	function automatic cpu16_pkg::word_t slot(input int j);
		return cpu16_pkg::word_t'(16'h20 + 2 * nt + j);
	endfunction

	task automatic put_word(input cpu16_pkg::word_t w);
		prog[nt][np] = w;
		np = np + 1;
	endtask

	task automatic load_const(input cpu16_pkg::reg_idx_t r, input cpu16_pkg::word_t v);
		put_word({cpu16_pkg::IMM, v[15:4]});
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::MOV, r, v[3:0]});
	endtask

	task automatic store_reg(input cpu16_pkg::reg_idx_t r, input cpu16_pkg::word_t a);
		put_word({cpu16_pkg::IMM, a[15:4]});
		put_word({cpu16_pkg::LDST, 4'h1, r, a[3:0]});
	endtask

	task automatic load_reg(input cpu16_pkg::reg_idx_t r, input cpu16_pkg::word_t a);
		put_word({cpu16_pkg::IMM, a[15:4]});
		put_word({cpu16_pkg::LDST, 4'h0, r, a[3:0]});
	endtask

	task automatic add_expect(input cpu16_pkg::word_t a, input logic [16:0] r);
		eaddr[nt][ecnt[nt]] = a;
		edata[nt][ecnt[nt]] = r[15:0];
		ecnt[nt] = ecnt[nt] + 1;
	endtask

	// done store, then spin on a branch to itself
	task automatic end_program();
		store_reg(4'h0, cpu16_pkg::DONE_ADDR);
		put_word({cpu16_pkg::BRANCH, 1'b0, cpu16_pkg::BA, 4'h0, 4'(np)});
		plen[nt] = np;
		nt = nt + 1;
		np = 0;
	endtask

	// branch over a marker store that shows up only when not taken
	task automatic branch_case(input cpu16_pkg::branch_cond_e cond, input int mark,
		input logic [16:0] r);
		cpu16_pkg::word_t a;
		a = cpu16_pkg::word_t'(16'h40 + mark);
		put_word({cpu16_pkg::BRANCH, 1'b0, cond, 4'h0, 4'(np + 3)});
		store_reg(4'h0, a);
		if (!branch_taken(cond, r))
			add_expect(a, 17'h0);
	endtask

	task automatic build_table();
		cpu16_pkg::word_t a;
		cpu16_pkg::word_t b;
		cpu16_pkg::word_t c;
		logic [3:0]       s1;
		logic [3:0]       s2;
		logic [16:0]      f;
		a = cpu16_pkg::word_t'($random(seed));
		b = cpu16_pkg::word_t'($random(seed));
		c = cpu16_pkg::word_t'($random(seed));
		s1 = 4'($random(seed));
		s2 = 4'($random(seed));
		// add and sub with a mov rr right behind its source
		load_const(4'h1, a);
		load_const(4'h2, b);
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::MOV, 4'h3, 4'h1});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::ADD, 4'h1, 4'h2});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::SUB, 4'h3, 4'h2});
		store_reg(4'h1, slot(0));
		store_reg(4'h3, slot(1));
		add_expect(slot(0), alu_expect(cpu16_pkg::ADD, a, b));
		add_expect(slot(1), alu_expect(cpu16_pkg::SUB, a, b));
		end_program();
		// and, or
		load_const(4'h1, a);
		load_const(4'h2, b);
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::MOV, 4'h3, 4'h1});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::AND, 4'h1, 4'h2});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::OR, 4'h3, 4'h2});
		store_reg(4'h1, slot(0));
		store_reg(4'h3, slot(1));
		add_expect(slot(0), alu_expect(cpu16_pkg::AND, a, b));
		add_expect(slot(1), alu_expect(cpu16_pkg::OR, a, b));
		end_program();
		// xor, then add with a full 16-bit immediate
		load_const(4'h1, a);
		load_const(4'h2, b);
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::XOR, 4'h1, 4'h2});
		store_reg(4'h1, slot(0));
		put_word({cpu16_pkg::IMM, c[15:4]});
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::ADD, 4'h2, c[3:0]});
		store_reg(4'h2, slot(1));
		add_expect(slot(0), alu_expect(cpu16_pkg::XOR, a, b));
		add_expect(slot(1), alu_expect(cpu16_pkg::ADD, b, c));
		end_program();
		// shifts by random amounts
		load_const(4'h1, a);
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::MOV, 4'h3, 4'h1});
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::SHL, 4'h1, s1});
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::SHR, 4'h3, s2});
		store_reg(4'h1, slot(0));
		store_reg(4'h3, slot(1));
		add_expect(slot(0), alu_expect(cpu16_pkg::SHL, a, {12'h0, s1}));
		add_expect(slot(1), alu_expect(cpu16_pkg::SHR, a, {12'h0, s2}));
		end_program();
		// inc / dec chain and back-to-back readers
		load_const(4'h1, a);
		put_word({cpu16_pkg::NOP_GRP, cpu16_pkg::SUB_INC, 4'h0, 4'h1});
		put_word({cpu16_pkg::NOP_GRP, cpu16_pkg::SUB_INC, 4'h0, 4'h1});
		put_word({cpu16_pkg::NOP_GRP, cpu16_pkg::SUB_DEC, 4'h0, 4'h1});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::MOV, 4'h2, 4'h1});
		put_word({cpu16_pkg::ALU_RR, cpu16_pkg::ADD, 4'h2, 4'h2});
		store_reg(4'h1, slot(0));
		store_reg(4'h2, slot(1));
		b = a + 16'd1;
		add_expect(slot(0), {1'b0, b});
		add_expect(slot(1), alu_expect(cpu16_pkg::ADD, b, b));
		end_program();
		// flags from mov 0 or from 0 - 1 with four branches each
		for (int g = 0; g < 4; g++) begin
			if (g % 2 == 0) begin
				put_word({cpu16_pkg::ALU_RI, cpu16_pkg::MOV, 4'h1, 4'h0});
				f = alu_expect(cpu16_pkg::MOV, 16'h0, 16'h0);
			end else begin
				put_word({cpu16_pkg::ALU_RI, cpu16_pkg::SUB, 4'h2, 4'h1});
				f = alu_expect(cpu16_pkg::SUB, 16'h0, 16'h1);
			end
			for (int k = 0; k < 4; k++)
				branch_case(cpu16_pkg::branch_cond_e'(3'((g / 2) * 4 + k)), 4 * g + k, f);
			end_program();
		end
		// store, load back through the shared port, add
		load_const(4'h1, c);
		store_reg(4'h1, slot(0));
		load_reg(4'h2, slot(0));
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::ADD, 4'h2, 4'h3});
		store_reg(4'h2, slot(1));
		add_expect(slot(0), {1'b0, c});
		add_expect(slot(1), alu_expect(cpu16_pkg::ADD, c, 16'h3));
		end_program();
		// prefix dropped by a nop and by an inc
		put_word({cpu16_pkg::IMM, 12'hABC});
		put_word(cpu16_pkg::NOP_WORD);
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::ADD, 4'h1, 4'h5});
		put_word({cpu16_pkg::IMM, 12'h123});
		put_word({cpu16_pkg::NOP_GRP, cpu16_pkg::SUB_INC, 4'h0, 4'h3});
		put_word({cpu16_pkg::ALU_RI, cpu16_pkg::ADD, 4'h3, 4'h3});
		store_reg(4'h1, slot(0));
		store_reg(4'h3, slot(1));
		add_expect(slot(0), alu_expect(cpu16_pkg::ADD, 16'h0, 16'h5));
		add_expect(slot(1), alu_expect(cpu16_pkg::ADD, 16'h1, 16'h3));
		end_program();
	endtask

	task automatic load_program(input int t);
		test_idx = t;
		cur_cnt  = ecnt[t];
		for (int j = 0; j < 4; j++) begin
			cur_addr[j] = eaddr[t][j];
			cur_data[j] = edata[t][j];
		end
		for (int i = 0; i < 256; i++)
			ram[i] <= (i < plen[t]) ? prog[t][i] : {~8'(i), 8'(i)};
	endtask

	initial begin
		CLK         = 1'b0;
		RSTb        = 1'b0;
		mem_rdata  <= '0;
		seed        = 32'h12bd388a;
		nt          = 0;
		np          = 0;
		test_idx    = 0;
		cur_cnt     = 0;
		cycle_limit = 0;
		for (int j = 0; j < 4; j++) begin
			cur_addr[j] = '0;
			cur_data[j] = '0;
		end
		build_table();
		for (int i = 0; i < nt; i++)
			cycle_limit = cycle_limit + 12 * plen[i] + 50;
		for (int t = 0; t < nt; t++) begin
			RSTb = 1'b0;
			@(posedge CLK);
			#1;
			load_program(t);
			repeat (9) @(posedge CLK);
			#1 RSTb = 1'b1;
			while (!done && !timed_out) begin
				@(posedge CLK);
				#1;
			end
			if (timed_out)
				break;
		end
		$display("%0d of %0d tests passed, %0d failed", pass_tests, nt, fail_tests);
		if (!timed_out && fail_tests == 0 && pass_tests == nt) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/cpu16_pkg.sv
verilog/alu16.sv
verilog/register_file.sv
verilog/fetch_mem_port.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu16_top.sv
test/tb_checker.sv
test/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1
